// ==== verilog/c64_loader_pkg.sv ====
package c64_loader_pkg;

	// ============================================================
	// Download indices
	// ============================================================

	// Host index of a PRG file
	localparam logic [7:0] PRG_INDEX = 8'd4;

	// ============================================================
	// BASIC pointer setup
	// ============================================================

	// First address past the page-zero walk
	localparam logic [8:0] MEMINIT_LAST = 9'h100;

	// BASIC program start as left by a cold reset
	localparam logic [15:0] TXT_START = 16'h0801;

	// C64 address, seen either as one word or as two bytes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} c64_addr_u;

endpackage

// ==== verilog/prg_header_parser.sv ====
`timescale 1ns/1ps

module prg_header_parser #(
	parameter int ADDR_W = 25
) (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      ioctl_download_i,
	input  logic [7:0]                ioctl_index_i,
	input  logic                      ioctl_wr_i,
	input  logic [ADDR_W-1:0]         ioctl_addr_i,
	input  logic [7:0]                ioctl_data_i,
	input  logic                      hdr_ack_i,
	output logic                      hdr_req_o,
	output logic [ADDR_W-1:0]         hdr_addr_o,
	output logic [7:0]                hdr_data_o,
	output c64_loader_pkg::c64_addr_u prg_end_o,
	output logic                      prg_active_o
);
	import c64_loader_pkg::*;

	logic      is_prg;
	logic      prg_wr;
	logic      hdr_byte;
	c64_addr_u load_addr;
	c64_addr_u end_addr;

	assign is_prg   = (ioctl_index_i == PRG_INDEX);
	assign prg_wr   = ioctl_wr_i && ioctl_download_i && is_prg;
	// Offsets 0 and 1 carry the load address
	assign hdr_byte = (ioctl_addr_i[ADDR_W-1:1] == '0);

	// Write request, held until the slot writer takes it
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_req_o <= 1'b0;
		end else if (prg_wr && !hdr_byte) begin
			hdr_req_o <= 1'b1;
		end else if (hdr_ack_i) begin
			hdr_req_o <= 1'b0;
		end
	end

	// ============================================================
	// Load and end address tracking
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (prg_wr) begin
			if (hdr_byte) begin
				if (ioctl_addr_i[0]) begin
					load_addr.bytes.hi <= ioctl_data_i;
					end_addr.bytes.hi  <= ioctl_data_i;
				end else begin
					load_addr.bytes.lo <= ioctl_data_i;
					end_addr.bytes.lo  <= ioctl_data_i;
				end
			end else begin
				hdr_data_o    <= ioctl_data_i;
				// End pointer runs one past the last byte
				end_addr.word <= end_addr.word + 16'd1;
			end
		end
		// Next byte goes to the following location
		if (hdr_ack_i) begin
			load_addr.word <= load_addr.word + 16'd1;
		end
	end

	assign hdr_addr_o   = {{(ADDR_W-16){1'b0}}, load_addr.word};
	assign prg_end_o    = end_addr;
	assign prg_active_o = (ioctl_download_i && is_prg) || hdr_req_o;

endmodule

// ==== verilog/basic_ptr_init.sv ====
`timescale 1ns/1ps

module basic_ptr_init (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      ioctl_download_i,
	input  logic [7:0]                ioctl_index_i,
	input  c64_loader_pkg::c64_addr_u prg_end_i,
	input  logic                      ptr_ack_i,
	output logic                      ptr_req_o,
	output logic [7:0]                ptr_addr_o,
	output logic [7:0]                ptr_data_o,
	output logic                      meminit_busy_o
);
	import c64_loader_pkg::*;

	c64_addr_u  txt_start;
	logic       prg_dl;
	logic       start;
	logic       busy;
	logic [8:0] walk_addr;
	logic       ptr_hit;
	logic [7:0] ptr_val;

	assign txt_start = TXT_START;
	// Falling edge of a PRG download
	assign start     = prg_dl && !ioctl_download_i;

	// ============================================================
	// Page-zero pointer map
	// ============================================================

	always_comb begin
		ptr_hit = 1'b1;
		ptr_val = 8'h00;
		case (walk_addr[7:0])
			// TXT keeps its reset value
			8'h2B: ptr_val = txt_start.bytes.lo;
			8'h2C: ptr_val = txt_start.bytes.hi;
			// SAVE_START cleared as after reset
			8'hAC, 8'hAD: ptr_val = 8'h00;
			// VAR, ARY, STR and LOAD_END all point at the program end
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_val = prg_end_i.bytes.lo;
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_val = prg_end_i.bytes.hi;
			default: ptr_hit = 1'b0;
		endcase
	end

	// ============================================================
	// Walk control
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			prg_dl    <= 1'b0;
			busy      <= 1'b0;
			ptr_req_o <= 1'b0;
			walk_addr <= '0;
		end else begin
			prg_dl <= ioctl_download_i && (ioctl_index_i == PRG_INDEX);
			if (start) begin
				busy      <= 1'b1;
				walk_addr <= '0;
			end else if (busy && !ptr_req_o) begin
				if (walk_addr == MEMINIT_LAST) begin
					busy <= 1'b0;
				end else if (ptr_hit) begin
					ptr_req_o <= 1'b1;
				end else begin
					walk_addr <= walk_addr + 9'd1;
				end
			end else if (ptr_ack_i) begin
				ptr_req_o <= 1'b0;
				walk_addr <= walk_addr + 9'd1;
			end
		end
	end

	// Data frozen while a request is outstanding
	always_ff @(posedge clk_sys) begin
		if (!ptr_req_o) begin
			ptr_data_o <= ptr_val;
		end
	end

	assign ptr_addr_o     = walk_addr[7:0];
	assign meminit_busy_o = busy || start;

endmodule

// ==== verilog/mem_slot_writer.sv ====
`timescale 1ns/1ps

module mem_slot_writer #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              io_cycle_i,
	input  logic              hdr_req_i,
	input  logic [ADDR_W-1:0] hdr_addr_i,
	input  logic [7:0]        hdr_data_i,
	input  logic              ptr_req_i,
	input  logic [7:0]        ptr_addr_i,
	input  logic [7:0]        ptr_data_i,
	output logic              hdr_ack_o,
	output logic              ptr_ack_o,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [7:0]        mem_data_o
);
	logic io_cycle_d;
	logic slot_open;
	logic slot_close;
	logic slot_start;

	// Slot begins when io_cycle drops, ends once it is back high
	assign slot_open  = io_cycle_d && !io_cycle_i;
	assign slot_close = io_cycle_d && io_cycle_i;
	// A slot is free only once the previous write has been released
	assign slot_start = slot_open && !mem_ce_o;

	// ============================================================
	// Strobes and acknowledges
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			hdr_ack_o  <= 1'b0;
			ptr_ack_o  <= 1'b0;
			mem_ce_o   <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			hdr_ack_o  <= 1'b0;
			ptr_ack_o  <= 1'b0;
			if (slot_start && (hdr_req_i || ptr_req_i)) begin
				mem_ce_o  <= 1'b1;
				mem_we_o  <= 1'b1;
				// File data wins if both happen to be waiting
				hdr_ack_o <= hdr_req_i;
				ptr_ack_o <= !hdr_req_i;
			end else if (slot_close) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	// Address and data latched at slot start
	always_ff @(posedge clk_sys) begin
		if (slot_start) begin
			if (hdr_req_i) begin
				mem_addr_o <= hdr_addr_i;
				mem_data_o <= hdr_data_i;
			end else begin
				mem_addr_o <= {{(ADDR_W-8){1'b0}}, ptr_addr_i};
				mem_data_o <= ptr_data_i;
			end
		end
	end

endmodule

// ==== verilog/c64_loader.sv ====
`timescale 1ns/1ps

module c64_loader #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              ioctl_download_i,
	input  logic [7:0]        ioctl_index_i,
	input  logic              ioctl_wr_i,
	input  logic [ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]        ioctl_data_i,
	input  logic              io_cycle_i,
	output logic              ioctl_wait_o,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [7:0]        mem_data_o,
	output logic              loader_busy_o
);
	import c64_loader_pkg::*;

	logic              hdr_req;
	logic              hdr_ack;
	logic [ADDR_W-1:0] hdr_addr;
	logic [7:0]        hdr_data;
	c64_addr_u         prg_end;
	logic              prg_active;
	logic              ptr_req;
	logic              ptr_ack;
	logic [7:0]        ptr_addr;
	logic [7:0]        ptr_data;
	logic              meminit_busy;

	// ============================================================
	// PRG stream to write requests
	// ============================================================

	prg_header_parser #(.ADDR_W(ADDR_W)) parser_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.ioctl_download_i(ioctl_download_i), .ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i), .ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i),
		.hdr_ack_i(hdr_ack), .hdr_req_o(hdr_req), .hdr_addr_o(hdr_addr),
		.hdr_data_o(hdr_data), .prg_end_o(prg_end), .prg_active_o(prg_active)
	);

	// BASIC pointers once the file is in
	basic_ptr_init ptr_init_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.ioctl_download_i(ioctl_download_i), .ioctl_index_i(ioctl_index_i),
		.prg_end_i(prg_end), .ptr_ack_i(ptr_ack), .ptr_req_o(ptr_req),
		.ptr_addr_o(ptr_addr), .ptr_data_o(ptr_data), .meminit_busy_o(meminit_busy)
	);

	mem_slot_writer #(.ADDR_W(ADDR_W)) writer_i (
		.clk_sys(clk_sys), .reset_n(reset_n), .io_cycle_i(io_cycle_i),
		.hdr_req_i(hdr_req), .hdr_addr_i(hdr_addr), .hdr_data_i(hdr_data),
		.ptr_req_i(ptr_req), .ptr_addr_i(ptr_addr), .ptr_data_i(ptr_data),
		.hdr_ack_o(hdr_ack), .ptr_ack_o(ptr_ack), .mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o)
	);

	// Host holds off while a file byte waits for its slot
	assign ioctl_wait_o  = hdr_req;
	assign loader_busy_o = prg_active || meminit_busy;

endmodule

// ==== sim/tb_c64_loader.sv ====
`timescale 1ns/1ps

module tb_c64_loader;
	import c64_loader_pkg::*;

	localparam int ADDR_W      = 25;
	localparam int TIMEOUT     = 2000;
	localparam int N_DOWNLOADS = 10;
	localparam int SEED        = 32'h9d2f_3f31;

	// BASIC pointer locations in the order the page-zero walk reaches them
	localparam logic [7:0] PTR_ADDRS [12] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h30,
		8'h31, 8'h32, 8'hAC, 8'hAD, 8'hAE, 8'hAF
	};

	logic              clk_sys = 1'b0;
	logic              reset_n;
	logic              ioctl_download_i;
	logic [7:0]        ioctl_index_i;
	logic              ioctl_wr_i;
	logic [ADDR_W-1:0] ioctl_addr_i;
	logic [7:0]        ioctl_data_i;
	logic              io_cycle_i;
	logic              ioctl_wait_o;
	logic              mem_ce_o;
	logic              mem_we_o;
	logic [ADDR_W-1:0] mem_addr_o;
	logic [7:0]        mem_data_o;
	logic              loader_busy_o;

	// Write log of the memory model
	logic [ADDR_W-1:0] wr_addr_q [$];
	logic [7:0]        wr_data_q [$];
	time               wr_time_q [$];
	logic              ce_d = 1'b0;
	logic              quiet_check;
	int                busy_cycles = 0;
	int                errors;
	int                timeouts;
	int                expected_total;
	bit                aborted;

	c64_loader #(.ADDR_W(ADDR_W)) dut_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.ioctl_download_i(ioctl_download_i), .ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i), .ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i),
		.io_cycle_i(io_cycle_i), .ioctl_wait_o(ioctl_wait_o),
		.mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o), .loader_busy_o(loader_busy_o)
	);

	always #10 clk_sys = ~clk_sys;

	// ============================================================
	// Slot traffic and memory model
	// ============================================================

	// Single-cycle high phases open slots that the writer must skip
	initial begin : slot_traffic
		int high_len;
		int low_len;
		@(posedge clk_sys);
		forever begin
			high_len = int'($urandom_range(6, 1));
			low_len  = int'($urandom_range(6, 1));
			repeat (high_len) begin
				io_cycle_i <= 1'b1;
				@(posedge clk_sys);
			end
			repeat (low_len) begin
				io_cycle_i <= 1'b0;
				@(posedge clk_sys);
			end
		end
	end

	// A write is taken on the rising edge of mem_ce_o
	always @(posedge clk_sys) begin
		if (mem_ce_o && mem_we_o && !ce_d) begin
			wr_addr_q.push_back(mem_addr_o);
			wr_data_q.push_back(mem_data_o);
			wr_time_q.push_back($time);
		end
		ce_d <= mem_ce_o;
		if (quiet_check && loader_busy_o) begin
			busy_cycles++;
		end
	end

	// ============================================================
	// Host side helpers
	// ============================================================

	function automatic logic [7:0] ptr_expect(input logic [7:0] a, input logic [15:0] prg_end);
		case (a)
			8'h2B: return 8'h01;
			8'h2C: return 8'h08;
			8'h2D, 8'h2F, 8'h31, 8'hAE: return prg_end[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: return prg_end[15:8];
			default: return 8'h00;
		endcase
	endfunction

	function automatic bit is_ptr_addr(input logic [7:0] a);
		for (int i = 0; i < 12; i++) begin
			if (PTR_ADDRS[i] == a) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic expect_low(input string name, input logic value);
		if (value !== 1'b0) begin
			errors++;
			$display("MISMATCH at %0t: %s expected 0, got %b", $time, name, value);
		end
	endtask

	task automatic wait_host_ready();
		int t;
		t = 0;
		while (ioctl_wait_o && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (ioctl_wait_o) begin
			$display("Timeout: ioctl_wait_o stayed high for %0d cycles at %0t", TIMEOUT, $time);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_loader_idle();
		int t;
		t = 0;
		while (loader_busy_o && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (loader_busy_o) begin
			$display("Timeout: loader_busy_o stayed high for %0d cycles at %0t", TIMEOUT, $time);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	// One strobe, then a random pause before the next byte
	task automatic send_byte(input logic [ADDR_W-1:0] offset, input logic [7:0] value);
		if (aborted) begin
			return;
		end
		wait_host_ready();
		if (aborted) begin
			return;
		end
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= offset;
		ioctl_data_i <= value;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		@(posedge clk_sys);
		repeat (int'($urandom_range(4, 0))) @(posedge clk_sys);
	endtask

	task automatic check_write(input int idx, input logic [ADDR_W-1:0] exp_addr,
			input logic [7:0] exp_data);
		if (wr_addr_q[idx] !== exp_addr) begin
			errors++;
			$display("MISMATCH at %0t: mem_addr_o expected %h, got %h",
				wr_time_q[idx], exp_addr, wr_addr_q[idx]);
		end
		if (wr_data_q[idx] !== exp_data) begin
			errors++;
			$display("MISMATCH at %0t: mem_data_o expected %h, got %h",
				wr_time_q[idx], exp_data, wr_data_q[idx]);
		end
	endtask

	// ============================================================
	// Downloads
	// ============================================================

	task automatic run_prg();
		logic [15:0] load;
		logic [15:0] prg_end;
		logic [7:0]  data [$];
		int          n_data;
		int          first;
		int          got;
		if (aborted) begin
			return;
		end
		load    = 16'($urandom_range(32'hBF00, 32'h0400));
		n_data  = int'($urandom_range(40, 2));
		prg_end = load + 16'(n_data);
		first   = wr_addr_q.size();
		ioctl_index_i    <= PRG_INDEX;
		ioctl_download_i <= 1'b1;
		send_byte(ADDR_W'(0), load[7:0]);
		send_byte(ADDR_W'(1), load[15:8]);
		for (int k = 0; k < n_data; k++) begin
			data.push_back(8'($urandom()));
			send_byte(ADDR_W'(k + 2), data[k]);
		end
		// Last data byte must be in memory before the download ends
		wait_host_ready();
		if (aborted) begin
			return;
		end
		ioctl_download_i <= 1'b0;
		@(posedge clk_sys);
		wait_loader_idle();
		if (aborted) begin
			return;
		end
		expected_total += n_data + 12;
		got = wr_addr_q.size() - first;
		if (got != n_data + 12) begin
			errors++;
			$display("PRG at %h with %0d bytes gave %0d memory writes, expected %0d",
				load, n_data, got, n_data + 12);
		end
		for (int k = 0; k < n_data && k < got; k++) begin
			check_write(first + k, ADDR_W'(int'(load) + k), data[k]);
		end
		for (int k = 0; k < 12 && n_data + k < got; k++) begin
			check_write(first + n_data + k, ADDR_W'(PTR_ADDRS[k]),
				ptr_expect(PTR_ADDRS[k], prg_end));
		end
		for (int i = first; i < wr_addr_q.size(); i++) begin
			if (wr_addr_q[i] < ADDR_W'(256) && !is_ptr_addr(wr_addr_q[i][7:0])) begin
				errors++;
				$display("Page-zero address %h was written outside the BASIC pointers",
					wr_addr_q[i]);
			end
		end
	endtask

	// Any other file kind must leave memory and the busy line alone
	task automatic run_other();
		int n_data;
		int first;
		int busy_before;
		if (aborted) begin
			return;
		end
		n_data      = int'($urandom_range(20, 2));
		first       = wr_addr_q.size();
		busy_before = busy_cycles;
		quiet_check      <= 1'b1;
		ioctl_index_i    <= 8'($urandom_range(15, 5));
		ioctl_download_i <= 1'b1;
		for (int k = 0; k < n_data + 2; k++) begin
			send_byte(ADDR_W'(k), 8'($urandom()));
		end
		if (aborted) begin
			return;
		end
		ioctl_download_i <= 1'b0;
		repeat (300) @(posedge clk_sys);
		quiet_check <= 1'b0;
		@(posedge clk_sys);
		if (wr_addr_q.size() != first) begin
			errors++;
			$display("Download with a non-PRG index wrote %0d bytes to memory",
				wr_addr_q.size() - first);
		end
		if (busy_cycles != busy_before) begin
			errors++;
			$display("loader_busy_o went high for %0d cycles during a non-PRG download",
				busy_cycles - busy_before);
		end
	endtask

	initial begin : main
		int seed_dummy;
		seed_dummy       = $urandom(SEED);
		errors           = 0;
		timeouts         = 0;
		expected_total   = 0;
		aborted          = 1'b0;
		quiet_check      = 1'b0;
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'h00;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = 8'h00;
		io_cycle_i       = 1'b0;

		repeat (16) @(posedge clk_sys);
		expect_low("mem_ce_o", mem_ce_o);
		expect_low("mem_we_o", mem_we_o);
		expect_low("ioctl_wait_o", ioctl_wait_o);
		expect_low("loader_busy_o", loader_busy_o);
		reset_n <= 1'b1;
		repeat (4) @(posedge clk_sys);

		for (int i = 0; i < N_DOWNLOADS; i++) begin
			if (i % 4 == 2) begin
				run_other();
			end else begin
				run_prg();
			end
		end

		if (!aborted && wr_addr_q.size() != expected_total) begin
			errors++;
			$display("Total memory writes %0d, expected %0d", wr_addr_q.size(), expected_total);
		end

		$display("Check errors: %0d, timeouts: %0d, memory writes: %0d",
			errors, timeouts, wr_addr_q.size());
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== all.f ====
verilog/c64_loader_pkg.sv
verilog/prg_header_parser.sv
verilog/basic_ptr_init.sv
verilog/mem_slot_writer.sv
verilog/c64_loader.sv
sim/tb_c64_loader.sv

// ==== run.sh ====
#!/bin/sh
# Build the PRG loader testbench with Verilator, run it and scan the log

LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --top-module tb_c64_loader -f all.f -o tb_c64_loader \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_c64_loader > "$LOG" 2>&1 \
	|| { cat "$LOG"; echo "Simulator exited with an error"; exit 1; }

cat "$LOG"

grep -qF "** FAIL **" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -qF "** PASS **" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
